/* build.f */
rtl/ht_cfg_pkg.sv
rtl/ht_types_pkg.sv
rtl/ht_group_ram.sv
rtl/ht_cpu_port.sv
rtl/ht_hash.sv
rtl/ht_way_match.sv
rtl/ht_walk_ctrl.sv
rtl/hash_table.sv
verif/tb_hash_table.sv

/* verif/tb_hash_table.sv */
module tb_hash_table;

	// ==============================
	// Run length
	// ==============================
	localparam int CLK_PERIOD  = 100;
	localparam int CLEAR_OPS   = ht_cfg_pkg::NUM_GROUPS * ht_cfg_pkg::NUM_WAYS;
	localparam int RB_OPS      = 16;                  // Read-back slots
	localparam int HIT_OPS     = 6;
	localparam int BOUNCE_OPS  = 4;
	localparam int EARLY_OPS   = 2;
	localparam int LIMIT_OPS   = 2;
	// Rough count of writes, reads and lookups over all scenarios
	localparam int NUM_OPS = CLEAR_OPS + 3 * RB_OPS + 10 * HIT_OPS + 50 * BOUNCE_OPS
		+ 12 * EARLY_OPS + 75 * LIMIT_OPS + 40;

	logic                                clk;
	logic                                rst_n;
	logic                                cs;
	logic                                we;
	logic [ht_cfg_pkg::CPU_ADR_BITS-1:0] cpu_adr;
	logic [ht_types_pkg::ENTRY_BITS-1:0] cpu_wdata;
	logic [ht_types_pkg::ENTRY_BITS-1:0] cpu_rdata;
	logic                                cpu_ack;
	logic                                vreq;
	logic [ht_cfg_pkg::VADR_BITS-1:0]    vadr;
	logic [ht_cfg_pkg::ASID_BITS-1:0]    asid;
	logic                                busy;
	logic [ht_cfg_pkg::PADR_BITS-1:0]    padr;
	logic                                padrv;
	logic                                page_fault;
	logic [ht_cfg_pkg::VADR_BITS-1:0]    fault_adr;
	logic [ht_cfg_pkg::ASID_BITS-1:0]    fault_asid;
	logic [ht_cfg_pkg::GROUP_BITS-1:0]   fault_group;

	// Mirror of every CPU write
	logic [ht_types_pkg::ENTRY_BITS-1:0] shadow [ht_cfg_pkg::NUM_GROUPS][ht_cfg_pkg::NUM_WAYS];

	integer seed;
	int     cyc;                  // Rising edges since time 0
	int     checks;
	int     value_errs;
	int     other_errs;
	int     results;              // Result pulses seen by the compare process
	bit     pending;              // Lookup outstanding
	// Expected result of the outstanding lookup
	bit                                exp_hit;
	logic [ht_cfg_pkg::PADR_BITS-1:0]  exp_padr;
	logic [ht_cfg_pkg::GROUP_BITS-1:0] exp_group;
	int                                exp_probes;
	logic [ht_cfg_pkg::VADR_BITS-1:0]  exp_vadr;
	logic [ht_cfg_pkg::ASID_BITS-1:0]  exp_asid;
	int                                vreq_cyc;
	// Scenario scratch
	logic [ht_cfg_pkg::VPN_BITS-1:0]   t_vpn;
	logic [ht_cfg_pkg::ASID_BITS-1:0]  t_asid;
	logic [ht_cfg_pkg::PAGE_BITS-1:0]  t_off;
	logic [ht_cfg_pkg::GROUP_BITS-1:0] t_base;
	logic [ht_cfg_pkg::GROUP_BITS-1:0] rb_g [RB_OPS];
	logic [ht_cfg_pkg::WAY_BITS-1:0]   rb_w [RB_OPS];
	logic [ht_types_pkg::ENTRY_BITS-1:0] t_data;

	hash_table hash_table_inst (
		.clk(clk), .rst_n(rst_n),
		.cs(cs), .we(we), .cpu_adr(cpu_adr), .cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata), .cpu_ack(cpu_ack),
		.vreq(vreq), .vadr(vadr), .asid(asid),
		.busy(busy), .padr(padr), .padrv(padrv), .page_fault(page_fault),
		.fault_adr(fault_adr), .fault_asid(fault_asid), .fault_group(fault_group)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;
	always @(posedge clk) cyc <= cyc + 1;

	// ==============================
	// Reporting and model helpers
	// ==============================
	task automatic report_mismatch(input string name, input logic [63:0] expv,
		input logic [63:0] gotv);
		value_errs++;
		$display("FAIL t=%0t %s expected=%0h actual=%0h", $time, name, expv, gotv);
	endtask

	task automatic report_problem(input string msg);
		other_errs++;
		$display("ERROR t=%0t %s", $time, msg);
	endtask

	function automatic logic [ht_types_pkg::ENTRY_BITS-1:0] make_entry(input bit v,
		input bit g, input logic [7:0] as, input logic [19:0] vpn, input logic [15:0] ppn);
		logic [ht_types_pkg::ENTRY_BITS-1:0] e;
		e = '0;
		e[ht_types_pkg::E_VALID]  = v;
		e[ht_types_pkg::E_GLOBAL] = g;
		e[ht_types_pkg::E_ASID_LSB +: ht_cfg_pkg::ASID_BITS] = as;
		e[ht_types_pkg::E_VPN_LSB +: ht_cfg_pkg::VPN_BITS]   = vpn;
		e[ht_types_pkg::E_PPN_LSB +: ht_cfg_pkg::PPN_BITS]   = ppn;
		return e;
	endfunction

	// Low vpn bits XOR low asid bits plus one stride per bounce, mod 64
	function automatic logic [5:0] probe_group(input logic [19:0] vpn, input logic [7:0] as,
		input int b);
		return (vpn[5:0] ^ as[5:0]) + b * ht_cfg_pkg::BOUNCE_STRIDE;
	endfunction

	// Reference walk over the shadow table that returns the hit flag
	function automatic bit ref_lookup(input logic [31:0] va, input logic [7:0] as,
		output logic [27:0] pa, output logic [5:0] grp, output int probes);
		logic [ht_types_pkg::ENTRY_BITS-1:0] e;
		logic [5:0] g;
		bit found;
		bit stop;
		found  = 0;
		stop   = 0;
		pa     = '0;
		grp    = '0;
		probes = 0;
		for (int b = 0; b < ht_cfg_pkg::MAX_BOUNCE; b++) begin
			if (!stop) begin
				g      = probe_group(va[31:12], as, b);
				grp    = g;
				probes = b + 1;
				for (int w = 0; w < ht_cfg_pkg::NUM_WAYS; w++) begin
					e = shadow[g][w];
					if (!found && e[ht_types_pkg::E_VALID]
						&& e[ht_types_pkg::E_VPN_LSB +: 20] == va[31:12]
						&& (e[ht_types_pkg::E_GLOBAL]
						|| e[ht_types_pkg::E_ASID_LSB +: 8] == as)) begin
						found = 1;
						// Lowest way wins
						pa    = {e[ht_types_pkg::E_PPN_LSB +: 16], va[11:0]};
					end
					if (!e[ht_types_pkg::E_VALID])
						stop = 1;              // Empty way ends the walk
				end
				if (found)
					stop = 1;
			end
		end
		return found;
	endfunction

	// ==============================
	// CPU port tasks
	// ==============================
	task automatic cpu_access(input bit wr, input logic [5:0] g, input logic [2:0] w,
		input logic [ht_types_pkg::ENTRY_BITS-1:0] d);
		int start_cyc;
		int waited;
		logic [ht_types_pkg::ENTRY_BITS-1:0] expected;
		@(negedge clk);
		cs        = 1'b1;
		we        = wr;
		cpu_adr   = {g, w};
		cpu_wdata = d;
		start_cyc = cyc + 1;                    // Edge that samples cs
		if (wr)
			shadow[g][w] = d;
		expected = shadow[g][w];
		@(negedge clk);
		cs     = 1'b0;
		we     = 1'b0;
		waited = 0;
		while (!cpu_ack && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		checks++;
		if (!cpu_ack)
			report_problem("cpu_ack never arrived after cs");
		else begin
			assert (cyc - start_cyc == 2)
				else report_mismatch("cpu_ack latency", 2, cyc - start_cyc);
			if (!wr) begin
				assert (cpu_rdata == expected)
					else report_mismatch("cpu_rdata", expected, cpu_rdata);
			end
		end
	endtask

	task automatic clear_group(input logic [5:0] g);
		for (int w = 0; w < ht_cfg_pkg::NUM_WAYS; w++)
			cpu_access(1, g, w, '0);
	endtask

	// Valid entries whose vpn differs from the key in every way
	task automatic fill_other(input logic [5:0] g, input logic [19:0] vpn, input logic [7:0] as,
		input int n);
		for (int w = 0; w < n; w++)
			cpu_access(1, g, w, make_entry(1, 0, as, vpn ^ (w + 1), $random(seed)));
	endtask

	// Fresh random key for the next scenario
	task automatic pick_key();
		t_vpn  = $random(seed);
		t_asid = $random(seed);
		t_off  = $random(seed);
	endtask

	// ==============================
	// Lookup stimulus
	// ==============================
	task automatic lookup(input logic [31:0] va, input logic [7:0] as);
		int seen;
		int waited;
		@(negedge clk);
		exp_hit  = ref_lookup(va, as, exp_padr, exp_group, exp_probes);
		exp_vadr = va;
		exp_asid = as;
		vreq_cyc = cyc + 1;
		pending  = 1;
		seen     = results;
		vreq = 1'b1;
		vadr = va;
		asid = as;
		@(negedge clk);
		vreq   = 1'b0;
		vadr   = $random(seed);                 // Key must already be held inside
		asid   = $random(seed);
		waited = 0;
		while (results == seen && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (results == seen)
			report_problem("lookup produced neither padrv nor page_fault");
	endtask

	// Compare each result pulse with the reference
	always @(negedge clk) begin
		if (rst_n && (padrv || page_fault)) begin
			checks++;
			if (!pending)
				report_problem("result pulse with no lookup outstanding");
			else if (padrv && page_fault)
				report_problem("padrv and page_fault pulsed together");
			else if (padrv && !exp_hit)
				report_problem("translation returned where a page fault was expected");
			else if (page_fault && exp_hit)
				report_problem("page fault where a translation was expected");
			else if (padrv) begin
				assert (padr == exp_padr) else report_mismatch("padr", exp_padr, padr);
			end else begin
				assert (fault_adr == exp_vadr)
					else report_mismatch("fault_adr", exp_vadr, fault_adr);
				assert (fault_asid == exp_asid)
					else report_mismatch("fault_asid", exp_asid, fault_asid);
				assert (fault_group == exp_group)
					else report_mismatch("fault_group", exp_group, fault_group);
			end
			assert (cyc - vreq_cyc == 2 * exp_probes + 1)
				else report_mismatch("result latency", 2 * exp_probes + 1, cyc - vreq_cyc);
			assert (!busy) else report_mismatch("busy", 0, busy);
			pending = 0;
			results++;
		end else if (rst_n && pending && cyc >= vreq_cyc) begin
			assert (busy) else report_mismatch("busy", 1, busy);   // Held for the whole walk
		end
	end

	// ==============================
	// Watchdog
	// ==============================
	initial begin
		#(NUM_OPS * 20 * CLK_PERIOD);
		report_problem("timeout, run did not finish");
		$display("Checks %0d, value errors %0d, other errors %0d",
			checks, value_errs, other_errs);
		$display("TB FAILED");
		$finish;
	end

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		seed       = 32'h4f056ff8;
		clk        = 1'b0;
		rst_n      = 1'b0;
		cs         = 1'b0;
		we         = 1'b0;
		cpu_adr    = '0;
		cpu_wdata  = '0;
		vreq       = 1'b0;
		vadr       = '0;
		asid       = '0;
		cyc        = 0;
		checks     = 0;
		value_errs = 0;
		other_errs = 0;
		results    = 0;
		pending    = 0;
		repeat (8) @(negedge clk);
		assert (!(busy || padrv || page_fault || cpu_ack))
			else report_problem("outputs not low during reset");
		rst_n = 1'b1;

		for (int g = 0; g < ht_cfg_pkg::NUM_GROUPS; g++)
			clear_group(g);                          // RAM starts unknown

		// CPU read-back
		for (int i = 0; i < RB_OPS; i++) begin
			rb_g[i] = $random(seed);
			rb_w[i] = $random(seed);
			t_data  = {$random(seed), $random(seed)};
			cpu_access(1, rb_g[i], rb_w[i], t_data);
		end
		for (int i = 0; i < RB_OPS; i++)
			cpu_access(0, rb_g[i], rb_w[i], '0);
		for (int i = 0; i < RB_OPS; i++)
			cpu_access(1, rb_g[i], rb_w[i], '0);

		// Primary hit
		for (int i = 0; i < HIT_OPS; i++) begin
			pick_key();
			t_base = probe_group(t_vpn, t_asid, 0);
			cpu_access(1, t_base, $random(seed),
				make_entry(1, 0, t_asid, t_vpn, $random(seed)));
			lookup({t_vpn, t_off}, t_asid);
			clear_group(t_base);
		end

		// Bounce hit with the target one or two strides on
		for (int i = 0; i < BOUNCE_OPS; i++) begin
			pick_key();
			for (int b = 0; b <= i % 2; b++)
				fill_other(probe_group(t_vpn, t_asid, b), t_vpn, t_asid, 8);
			cpu_access(1, probe_group(t_vpn, t_asid, i % 2 + 1), $random(seed),
				make_entry(1, 0, t_asid, t_vpn, $random(seed)));
			lookup({t_vpn, t_off}, t_asid);
			for (int b = 0; b <= i % 2 + 1; b++)
				clear_group(probe_group(t_vpn, t_asid, b));
		end

		// Early fault in a group with free ways
		for (int i = 0; i < EARLY_OPS; i++) begin
			pick_key();
			fill_other(probe_group(t_vpn, t_asid, 0), t_vpn, t_asid, 3);
			lookup({t_vpn, t_off}, t_asid);
			clear_group(probe_group(t_vpn, t_asid, 0));
		end

		// Limit fault with the key one probe past the limit
		for (int i = 0; i < LIMIT_OPS; i++) begin
			pick_key();
			for (int b = 0; b < ht_cfg_pkg::MAX_BOUNCE; b++)
				fill_other(probe_group(t_vpn, t_asid, b), t_vpn, t_asid, 8);
			cpu_access(1, probe_group(t_vpn, t_asid, 4), 0,
				make_entry(1, 0, t_asid, t_vpn, $random(seed)));
			lookup({t_vpn, t_off}, t_asid);
			for (int b = 0; b <= ht_cfg_pkg::MAX_BOUNCE; b++)
				clear_group(probe_group(t_vpn, t_asid, b));
		end

		// Global entry under a foreign asid in the same group for both lookups
		pick_key();
		t_base = probe_group(t_vpn, t_asid, 0);
		cpu_access(1, t_base, 3, make_entry(1, 1, t_asid ^ 8'h5a, t_vpn, $random(seed)));
		lookup({t_vpn, t_off}, t_asid);
		lookup({t_vpn, t_off}, t_asid ^ 8'h80);
		clear_group(t_base);
		// Private entry looked up with a differing upper asid bit
		t_vpn = $random(seed);
		t_base = probe_group(t_vpn, t_asid, 0);
		cpu_access(1, t_base, 0, make_entry(1, 0, t_asid, t_vpn, $random(seed)));
		lookup({t_vpn, t_off}, t_asid);
		lookup({t_vpn, t_off}, t_asid ^ 8'h40);
		clear_group(t_base);

		repeat (4) @(negedge clk);
		$display("Checks %0d, value errors %0d, other errors %0d",
			checks, value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* rtl/hash_table.sv */
module hash_table (
	input  logic                                clk,
	input  logic                                rst_n,
	// CPU port
	input  logic                                cs,
	input  logic                                we,
	input  logic [ht_cfg_pkg::CPU_ADR_BITS-1:0] cpu_adr,
	input  logic [ht_types_pkg::ENTRY_BITS-1:0] cpu_wdata,
	output logic [ht_types_pkg::ENTRY_BITS-1:0] cpu_rdata,
	output logic                                cpu_ack,
	// Lookup port
	input  logic                                vreq,
	input  logic [ht_cfg_pkg::VADR_BITS-1:0]    vadr,
	input  logic [ht_cfg_pkg::ASID_BITS-1:0]    asid,
	output logic                                busy,
	output logic [ht_cfg_pkg::PADR_BITS-1:0]    padr,
	output logic                                padrv,
	output logic                                page_fault,
	output logic [ht_cfg_pkg::VADR_BITS-1:0]    fault_adr,
	output logic [ht_cfg_pkg::ASID_BITS-1:0]    fault_asid,
	output logic [ht_cfg_pkg::GROUP_BITS-1:0]   fault_group
);

	// CPU side of the RAM
	logic                                     ram_en;
	logic                                     ram_we;
	logic [ht_cfg_pkg::CPU_ADR_BITS-1:0]      ram_adr;
	logic [ht_types_pkg::ENTRY_BITS-1:0]      ram_wdata;
	logic [ht_types_pkg::ENTRY_BITS-1:0]      ram_rdata;
	// Walk side
	logic [ht_types_pkg::GROUP_BITS_WIDE-1:0] group_data;
	logic [ht_cfg_pkg::GROUP_BITS-1:0]        group;
	logic [ht_cfg_pkg::VPN_BITS-1:0]          key_vpn;
	logic [ht_cfg_pkg::ASID_BITS-1:0]         key_asid;
	logic [ht_cfg_pkg::BOUNCE_BITS-1:0]       bounce;
	logic [ht_cfg_pkg::NUM_WAYS-1:0]          hits;
	logic [ht_cfg_pkg::NUM_WAYS-1:0]          empties;

	ht_cpu_port cpu_port_inst (
		.clk(clk), .rst_n(rst_n),
		.cs(cs), .we(we), .cpu_adr(cpu_adr), .cpu_wdata(cpu_wdata),
		.ram_en(ram_en), .ram_we(ram_we), .ram_adr(ram_adr),
		.ram_wdata(ram_wdata), .ram_rdata(ram_rdata),
		.cpu_rdata(cpu_rdata), .cpu_ack(cpu_ack)
	);

	ht_group_ram group_ram_inst (
		.clk(clk),
		.ena(ram_en), .wea(ram_we), .addra(ram_adr), .dina(ram_wdata), .douta(ram_rdata),
		.addrb(group), .doutb(group_data)
	);

	ht_hash hash_inst (
		.clk(clk), .rst_n(rst_n),
		.key_vpn(key_vpn), .key_asid(key_asid), .bounce(bounce),
		.group(group)
	);

	// ==============================
	// One comparator per way
	// ==============================
	for (genvar w = 0; w < ht_cfg_pkg::NUM_WAYS; w++) begin : g_way
		ht_way_match way_match_inst (
			.entry(group_data[w * ht_types_pkg::ENTRY_BITS +: ht_types_pkg::ENTRY_BITS]),
			.key_vpn(key_vpn), .key_asid(key_asid),
			.hit(hits[w]), .empty(empties[w])
		);
	end

	ht_walk_ctrl walk_ctrl_inst (
		.clk(clk), .rst_n(rst_n),
		.vreq(vreq), .vadr(vadr), .asid(asid),
		.hits(hits), .empties(empties), .group_data(group_data), .group(group),
		.key_vpn(key_vpn), .key_asid(key_asid), .bounce(bounce),
		.busy(busy), .padr(padr), .padrv(padrv), .page_fault(page_fault),
		.fault_adr(fault_adr), .fault_asid(fault_asid), .fault_group(fault_group)
	);

endmodule

/* rtl/ht_walk_ctrl.sv */
module ht_walk_ctrl (
	input  logic                                     clk,
	input  logic                                     rst_n,
	// Lookup request
	input  logic                                     vreq,
	input  logic [ht_cfg_pkg::VADR_BITS-1:0]         vadr,
	input  logic [ht_cfg_pkg::ASID_BITS-1:0]         asid,
	// Comparator results and group contents
	input  logic [ht_cfg_pkg::NUM_WAYS-1:0]          hits,
	input  logic [ht_cfg_pkg::NUM_WAYS-1:0]          empties,
	input  logic [ht_types_pkg::GROUP_BITS_WIDE-1:0] group_data,
	input  logic [ht_cfg_pkg::GROUP_BITS-1:0]        group,
	// To hash and comparators
	output logic [ht_cfg_pkg::VPN_BITS-1:0]          key_vpn,
	output logic [ht_cfg_pkg::ASID_BITS-1:0]         key_asid,
	output logic [ht_cfg_pkg::BOUNCE_BITS-1:0]       bounce,
	// Result
	output logic                                     busy,
	output logic [ht_cfg_pkg::PADR_BITS-1:0]         padr,
	output logic                                     padrv,
	output logic                                     page_fault,
	output logic [ht_cfg_pkg::VADR_BITS-1:0]         fault_adr,
	output logic [ht_cfg_pkg::ASID_BITS-1:0]         fault_asid,
	output logic [ht_cfg_pkg::GROUP_BITS-1:0]        fault_group
);

	ht_types_pkg::walk_state_e state;

	logic                              prime;      // First READ waits for the hash register
	logic [ht_cfg_pkg::PAGE_BITS-1:0]  key_off;    // Page offset of the held vadr
	logic                              accept;     // vreq taken this cycle
	logic                              in_check;
	logic                              hit_any;
	logic                              fault_now;  // Empty way seen or probes used up
	logic [ht_cfg_pkg::PPN_BITS-1:0]   hit_ppn;    // ppn of lowest hit way

	assign accept   = vreq && !busy;
	assign in_check = (state == ht_types_pkg::WALK_CHECK);
	assign hit_any  = |hits;
	// bounce already points one past the probe under check
	assign fault_now = in_check && !hit_any &&
		((|empties) || (bounce == ht_cfg_pkg::MAX_BOUNCE));

	// ==============================
	// Hit priority encoder
	// ==============================
	// Walk downwards so the lowest hit way is the last one assigned
	always_comb begin
		hit_ppn = '0;
		for (int w = ht_cfg_pkg::NUM_WAYS - 1; w >= 0; w--) begin
			if (hits[w])
				hit_ppn = group_data[w * ht_types_pkg::ENTRY_BITS + ht_types_pkg::E_PPN_LSB
					+: ht_cfg_pkg::PPN_BITS];
		end
	end

	// ==============================
	// Walk FSM
	// ==============================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= ht_types_pkg::WALK_IDLE;
			prime      <= 1'b0;
			bounce     <= '0;
			busy       <= 1'b0;
			padrv      <= 1'b0;
			page_fault <= 1'b0;
		end else begin
			padrv      <= 1'b0;               // Result strobes last one cycle
			page_fault <= 1'b0;
			case (state)
				ht_types_pkg::WALK_IDLE, ht_types_pkg::WALK_DONE: begin
					state <= ht_types_pkg::WALK_IDLE;
					if (accept) begin
						state  <= ht_types_pkg::WALK_READ;
						prime  <= 1'b1;        // Hash of the new key not yet registered
						bounce <= '0;
						busy   <= 1'b1;
					end
				end
				ht_types_pkg::WALK_READ: begin
					if (prime)
						prime <= 1'b0;          // Extra cycle on the first probe only
					else begin
						state  <= ht_types_pkg::WALK_CHECK;
						bounce <= bounce + 1'b1;   // Hash starts on the next group early
					end
				end
				ht_types_pkg::WALK_CHECK: begin
					if (hit_any) begin
						state <= ht_types_pkg::WALK_DONE;
						busy  <= 1'b0;
						padrv <= 1'b1;
					end else if (fault_now) begin
						state      <= ht_types_pkg::WALK_DONE;
						busy       <= 1'b0;
						page_fault <= 1'b1;
					end else
						state <= ht_types_pkg::WALK_READ;   // Full group, bounce
				end
				default: state <= ht_types_pkg::WALK_IDLE;
			endcase
		end
	end

	// ==============================
	// Key and result registers
	// ==============================
	always_ff @(posedge clk) begin
		if (accept) begin
			key_vpn  <= vadr[ht_cfg_pkg::VADR_BITS-1:ht_cfg_pkg::PAGE_BITS];
			key_off  <= vadr[ht_cfg_pkg::PAGE_BITS-1:0];
			key_asid <= asid;
		end
		if (in_check && hit_any)
			padr <= {hit_ppn, key_off};       // Physical page plus offset
		if (fault_now) begin
			fault_adr   <= {key_vpn, key_off};
			fault_asid  <= key_asid;
			fault_group <= group;             // Still the probed group at this edge
		end
	end

endmodule

/* rtl/ht_way_match.sv */
module ht_way_match (
	input  logic [ht_types_pkg::ENTRY_BITS-1:0] entry,
	input  logic [ht_cfg_pkg::VPN_BITS-1:0]     key_vpn,
	input  logic [ht_cfg_pkg::ASID_BITS-1:0]    key_asid,
	output logic                                hit,
	output logic                                empty
);

	logic valid;          // Entry in use
	logic global_pg;      // Entry visible to every asid
	logic vpn_eq;
	logic asid_eq;

	// Field pick from the packed entry
	assign valid     = entry[ht_types_pkg::E_VALID];
	assign global_pg = entry[ht_types_pkg::E_GLOBAL];

	assign vpn_eq  = entry[ht_types_pkg::E_VPN_LSB +: ht_cfg_pkg::VPN_BITS] == key_vpn;
	assign asid_eq = entry[ht_types_pkg::E_ASID_LSB +: ht_cfg_pkg::ASID_BITS] == key_asid;

	// Global pages skip the asid compare
	assign hit   = valid && vpn_eq && (global_pg || asid_eq);
	assign empty = !valid;            // Free slot, key cannot live further on

endmodule

/* rtl/ht_hash.sv */
module ht_hash (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [ht_cfg_pkg::VPN_BITS-1:0]      key_vpn,
	input  logic [ht_cfg_pkg::ASID_BITS-1:0]     key_asid,
	input  logic [ht_cfg_pkg::BOUNCE_BITS-1:0]   bounce,
	output logic [ht_cfg_pkg::GROUP_BITS-1:0]    group
);

	logic [ht_cfg_pkg::GROUP_BITS-1:0] base;      // Primary group
	logic [31:0]                       step;      // Bounce offset before wrap

	// Primary hash mixes the low vpn bits with the asid
	assign base = key_vpn[ht_cfg_pkg::GROUP_BITS-1:0] ^ key_asid[ht_cfg_pkg::GROUP_BITS-1:0];

	// Each bounce moves a fixed stride further round the table
	assign step = bounce * ht_cfg_pkg::BOUNCE_STRIDE;

	// ==============================
	// Probe group register
	// ==============================
	// Follows key and bounce one cycle late, drives RAM port B
	always_ff @(posedge clk) begin
		if (!rst_n)
			group <= '0;
		else
			group <= base + step[ht_cfg_pkg::GROUP_BITS-1:0];   // Wraps mod NUM_GROUPS
	end

endmodule

/* rtl/ht_cpu_port.sv */
module ht_cpu_port (
	input  logic                                clk,
	input  logic                                rst_n,
	// CPU strobes
	input  logic                                cs,
	input  logic                                we,
	input  logic [ht_cfg_pkg::CPU_ADR_BITS-1:0] cpu_adr,
	input  logic [ht_types_pkg::ENTRY_BITS-1:0] cpu_wdata,
	// RAM port A
	output logic                                ram_en,
	output logic                                ram_we,
	output logic [ht_cfg_pkg::CPU_ADR_BITS-1:0] ram_adr,
	output logic [ht_types_pkg::ENTRY_BITS-1:0] ram_wdata,
	input  logic [ht_types_pkg::ENTRY_BITS-1:0] ram_rdata,
	// CPU response
	output logic [ht_types_pkg::ENTRY_BITS-1:0] cpu_rdata,
	output logic                                cpu_ack
);

	logic [1:0] pend;     // Pending shift, bit 0 doubles as the RAM enable
	logic       start;    // Accepted access

	// New access only when nothing is in flight
	assign start  = cs && !(|pend);
	assign ram_en = pend[0];           // RAM acts one cycle after cs

	// ==============================
	// Control, with reset
	// ==============================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pend    <= 2'b00;
			ram_we  <= 1'b0;
			cpu_ack <= 1'b0;
		end else begin
			pend    <= {pend[0], start};
			cpu_ack <= pend[1];            // Two cycles after cs
			if (start)
				ram_we <= we;               // Held until the next access
		end
	end

	// ==============================
	// Address and data
	// ==============================
	always_ff @(posedge clk) begin
		if (start) begin
			ram_adr   <= cpu_adr;
			ram_wdata <= cpu_wdata;
		end
		if (pend[1] && !ram_we)
			cpu_rdata <= ram_rdata;         // RAM data settled since last edge
	end

endmodule

/* rtl/ht_group_ram.sv */
module ht_group_ram (
	input  logic                                     clk,
	// Port A, one entry at a time from the CPU side
	input  logic                                     ena,
	input  logic                                     wea,
	input  logic [ht_cfg_pkg::CPU_ADR_BITS-1:0]      addra,
	input  logic [ht_types_pkg::ENTRY_BITS-1:0]      dina,
	output logic [ht_types_pkg::ENTRY_BITS-1:0]      douta,
	// Port B, whole group for the walker
	input  logic [ht_cfg_pkg::GROUP_BITS-1:0]        addrb,
	output logic [ht_types_pkg::GROUP_BITS_WIDE-1:0] doutb
);

	// Group words, each split into per-way entry lanes
	logic [ht_cfg_pkg::NUM_WAYS-1:0][ht_types_pkg::ENTRY_BITS-1:0] mem [ht_cfg_pkg::NUM_GROUPS];

	logic [ht_cfg_pkg::GROUP_BITS-1:0] grp_a;     // Group part of addra
	logic [ht_cfg_pkg::WAY_BITS-1:0]   way_a;     // Way part of addra

	assign grp_a = addra[ht_cfg_pkg::WAY_BITS +: ht_cfg_pkg::GROUP_BITS];
	assign way_a = addra[ht_cfg_pkg::WAY_BITS-1:0];

	// ==============================
	// Port A
	// ==============================
	// Write touches only the addressed way lane
	// Read data is registered, douta holds during a write
	always_ff @(posedge clk) begin
		if (ena) begin
			if (wea)
				mem[grp_a][way_a] <= dina;
			else
				douta <= mem[grp_a][way_a];   // Valid the cycle after ena
		end
	end

	// ==============================
	// Port B
	// ==============================
	// Always enabled, all eight ways come out together
	always_ff @(posedge clk) begin
		doutb <= mem[addrb];                // One cycle after addrb
	end

endmodule

/* rtl/ht_types_pkg.sv */
package ht_types_pkg;

	// ==============================
	// Page table entry layout
	// ==============================
	// | valid | global | asid[7:0] | vpn[19:0] | ppn[15:0] |
	localparam int ENTRY_BITS = 46;

	localparam int E_VALID    = 45;                         // Entry in use
	localparam int E_GLOBAL   = 44;                         // Shared by all address spaces
	localparam int E_ASID_LSB = 36;                         // 43:36
	localparam int E_VPN_LSB  = 16;                         // 35:16
	localparam int E_PPN_LSB  = 0;                          // 15:0

	// One RAM word holds the whole group, way 0 in the low bits
	localparam int GROUP_BITS_WIDE = ht_cfg_pkg::NUM_WAYS * ENTRY_BITS;

	// ==============================
	// Walk FSM
	// ==============================
	typedef enum logic [1:0] {
		WALK_IDLE  = 2'd0,    // Waiting for vreq
		WALK_READ  = 2'd1,    // Group address on RAM port B
		WALK_CHECK = 2'd2,    // Group data at the comparators
		WALK_DONE  = 2'd3     // Result pulse cycle
	} walk_state_e;

endpackage

/* rtl/ht_cfg_pkg.sv */
package ht_cfg_pkg;

	// ==============================
	// Table geometry
	// ==============================
	localparam int NUM_WAYS     = 8;                        // Entries per group
	localparam int NUM_GROUPS   = 64;                       // Groups in the table
	localparam int GROUP_BITS   = 6;                        // log2(NUM_GROUPS)
	localparam int WAY_BITS     = 3;                        // log2(NUM_WAYS)
	localparam int CPU_ADR_BITS = GROUP_BITS + WAY_BITS;    // Group in upper bits, way in lower

	// ==============================
	// Address widths
	// ==============================
	localparam int VADR_BITS = 32;                          // Virtual address
	localparam int PAGE_BITS = 12;                          // 4 KiB pages
	localparam int VPN_BITS  = VADR_BITS - PAGE_BITS;      // 20 bit virtual page number
	localparam int PPN_BITS  = 16;                          // Physical page number
	localparam int PADR_BITS = PPN_BITS + PAGE_BITS;       // 28 bit physical address
	localparam int ASID_BITS = 8;

	// ==============================
	// Hash and bounce
	// ==============================
	localparam int MAX_BOUNCE    = 4;                       // Probes before giving up
	localparam int BOUNCE_STRIDE = 17;                      // Odd step, walks all groups
	localparam int BOUNCE_BITS   = 3;                       // Holds 0..MAX_BOUNCE

endpackage
